//--- include/prefetch_cfg.svh
`ifndef PREFETCH_CFG_SVH
`define PREFETCH_CFG_SVH

// line address and table geometry
`define PF_ADDR_WIDTH 27
`define PF_HASH_WIDTH 10

// issue queue slots
`define PF_QUEUE_DEPTH 4

// fetchable windows, inclusive line-address bounds
`define PF_WIN0_BASE  27'h000_0000
`define PF_WIN0_LIMIT 27'h00f_ffff
`define PF_WIN1_BASE  27'h200_0000
`define PF_WIN1_LIMIT 27'h2ff_ffff

`endif

//--- source/prefetch_pkg.sv
`default_nettype none

`include "prefetch_cfg.svh"

package prefetch_pkg;

    typedef logic [`PF_ADDR_WIDTH-1:0] line_addr_t;
    typedef logic [`PF_HASH_WIDTH-1:0] tbl_idx_t;
    typedef logic [1:0] ctr2_t;

    // tag holds the full line pc of the owner
    typedef struct packed {
        line_addr_t target;
        logic       valid;
        ctr2_t      taken;
        line_addr_t tag;
    } target_entry_t;

    // xor-fold of the line address onto the index width
    function automatic tbl_idx_t hash_index(input line_addr_t addr);
        tbl_idx_t h;
        h = '0;
        for (int i = 0; i < `PF_ADDR_WIDTH; i++) begin
            h[i % `PF_HASH_WIDTH] ^= addr[i];
        end
        return h;
    endfunction

    // saturating 2-bit step
    function automatic ctr2_t ctr_step(input ctr2_t ctr, input logic up);
        ctr2_t next;
        if (up) begin
            next = (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end else begin
            next = (ctr == 2'b00) ? ctr : ctr - 2'd1;
        end
        return next;
    endfunction

endpackage

`default_nettype wire

//--- source/table_ram.sv
`timescale 1ns/1ps
`default_nettype none

module table_ram #(
    parameter type payload_t = logic,
    parameter int idx_width = $bits(prefetch_pkg::tbl_idx_t),
    parameter payload_t init_value = '0
) (
    input  wire logic                 clk,
    input  wire logic [idx_width-1:0] raddr,
    output payload_t                  rdata,
    input  wire logic                 we,
    input  wire logic [idx_width-1:0] waddr,
    input  payload_t                  wdata
);

    localparam int depth = 2 ** idx_width;

    payload_t mem [depth];

    // power-up contents, not touched by reset
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = init_value;
        end
    end

    // read-before-write on a same-cycle collision
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

    a_waddr_known: assert property (
        @(posedge clk) we |-> !$isunknown(waddr)
    ) else $error("table_ram: unknown write address");

endmodule

`default_nettype wire

//--- source/io_window_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_cfg.svh"

module io_window_check (
    input  prefetch_pkg::line_addr_t cand_addr,
    output logic                     cand_allowed
);

    localparam prefetch_pkg::line_addr_t win0_base  = `PF_WIN0_BASE;
    localparam prefetch_pkg::line_addr_t win0_limit = `PF_WIN0_LIMIT;
    localparam prefetch_pkg::line_addr_t win1_base  = `PF_WIN1_BASE;
    localparam prefetch_pkg::line_addr_t win1_limit = `PF_WIN1_LIMIT;

    logic in_win0;
    logic in_win1;

    assign in_win0 = (cand_addr >= win0_base) && (cand_addr <= win0_limit);
    assign in_win1 = (cand_addr >= win1_base) && (cand_addr <= win1_limit);

    // anything outside both windows is a hole
    assign cand_allowed = in_win0 || in_win1;

endmodule

`default_nettype wire

//--- source/target_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module target_predictor (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                fetch_valid,
    input  prefetch_pkg::line_addr_t fetch_pc,
    output prefetch_pkg::ctr2_t      fetch_conf,
    output logic                     fetch_conf_valid,
    input  wire logic                conf_upd_valid,
    input  prefetch_pkg::line_addr_t conf_upd_pc,
    input  wire logic                conf_upd_up,
    input  prefetch_pkg::ctr2_t      conf_upd_ctr,
    input  wire logic                miss_valid,
    input  prefetch_pkg::line_addr_t miss_addr,
    input  wire logic                miss_is_data,
    output logic                     pred_valid,
    output prefetch_pkg::line_addr_t pred_addr
);

    prefetch_pkg::line_addr_t    last_pc;
    logic                        last_valid;
    logic                        lookup_q;
    logic                        stolen_q;
    prefetch_pkg::tbl_idx_t      anneal_idx_q;

    prefetch_pkg::tbl_idx_t      tgt_raddr;
    prefetch_pkg::tbl_idx_t      tgt_waddr;
    prefetch_pkg::target_entry_t tgt_rdata;
    prefetch_pkg::target_entry_t tgt_wdata;
    logic                        tgt_we;

    prefetch_pkg::tbl_idx_t      conf_raddr;
    prefetch_pkg::tbl_idx_t      conf_waddr;
    prefetch_pkg::ctr2_t         conf_rdata;
    prefetch_pkg::ctr2_t         conf_wdata;
    logic                        conf_we;

    logic                        anneal_now;
    logic                        seq_move;
    logic                        tag_hit;
    logic                        take_target;
    logic                        cand_allowed;
    prefetch_pkg::line_addr_t    cand_addr;
    prefetch_pkg::ctr2_t         taken_base;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_valid <= 1'b0;
            lookup_q   <= 1'b0;
            stolen_q   <= 1'b0;
        end else begin
            lookup_q <= fetch_valid;
            stolen_q <= anneal_now;
            if (fetch_valid) begin
                last_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            last_pc <= fetch_pc;
        end
        anneal_idx_q <= prefetch_pkg::hash_index(miss_addr);
    end

    // idle cycles re-read the last line so its entry stays on rdata for training
    assign tgt_raddr = prefetch_pkg::hash_index(fetch_valid ? fetch_pc : last_pc);

    table_ram #(
        .payload_t  (prefetch_pkg::target_entry_t),
        .idx_width  ($bits(prefetch_pkg::tbl_idx_t)),
        .init_value ('0)
    ) u_target_tbl (
        .clk   (clk),
        .raddr (tgt_raddr),
        .rdata (tgt_rdata),
        .we    (tgt_we),
        .waddr (tgt_waddr),
        .wdata (tgt_wdata)
    );

    assign tag_hit    = tgt_rdata.valid && (tgt_rdata.tag == last_pc);
    assign taken_base = tag_hit ? tgt_rdata.taken : 2'b00;
    assign seq_move   = (fetch_pc == last_pc + 1'b1);

    // train the previous line with where the stream actually went
    assign tgt_we           = fetch_valid && last_valid;
    assign tgt_waddr        = prefetch_pkg::hash_index(last_pc);
    assign tgt_wdata.target = fetch_pc;
    assign tgt_wdata.valid  = 1'b1;
    assign tgt_wdata.taken  = prefetch_pkg::ctr_step(taken_base, !seq_move);
    assign tgt_wdata.tag    = last_pc;

    // instruction misses steal the confidence read port
    assign anneal_now = miss_valid && !miss_is_data;
    assign conf_raddr = anneal_now ? prefetch_pkg::hash_index(miss_addr)
                                   : prefetch_pkg::hash_index(fetch_pc);

    table_ram #(
        .payload_t  (prefetch_pkg::ctr2_t),
        .idx_width  ($bits(prefetch_pkg::tbl_idx_t)),
        .init_value (2'b10)
    ) u_conf_tbl (
        .clk   (clk),
        .raddr (conf_raddr),
        .rdata (conf_rdata),
        .we    (conf_we),
        .waddr (conf_waddr),
        .wdata (conf_wdata)
    );

    // annealing write-back wins over the pipeline update
    assign conf_we    = stolen_q || conf_upd_valid;
    assign conf_waddr = stolen_q ? anneal_idx_q : prefetch_pkg::hash_index(conf_upd_pc);
    assign conf_wdata = stolen_q ? prefetch_pkg::ctr_step(conf_rdata, 1'b1)
                                 : prefetch_pkg::ctr_step(conf_upd_ctr, conf_upd_up);

    assign cand_addr = tgt_rdata.target;

    io_window_check u_window (
        .cand_addr    (cand_addr),
        .cand_allowed (cand_allowed)
    );

    assign take_target      = tag_hit && tgt_rdata.taken[1] && cand_allowed;
    assign pred_addr        = take_target ? tgt_rdata.target : last_pc + 1'b1;
    assign fetch_conf       = conf_rdata;
    assign fetch_conf_valid = lookup_q && !stolen_q;
    assign pred_valid       = fetch_conf_valid && conf_rdata[1];

    a_no_pred_when_stolen: assert property (
        @(posedge clk) disable iff (rst)
        anneal_now |=> !pred_valid && !fetch_conf_valid
    ) else $error("target_predictor: prediction on a stolen confidence read");

endmodule

`default_nettype wire

//--- source/prefetch_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_cfg.svh"

module prefetch_issue (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                pred_valid,
    input  prefetch_pkg::line_addr_t pred_addr,
    output logic                     pf_req,
    output prefetch_pkg::line_addr_t pf_addr,
    input  wire logic                pf_ack
);

    localparam int depth = `PF_QUEUE_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT_LOW
    } state_t;

    prefetch_pkg::line_addr_t queue [depth];
    prefetch_pkg::line_addr_t last_enq;
    logic                     last_enq_valid;
    logic [ptr_w-1:0]         wr_ptr;
    logic [ptr_w-1:0]         rd_ptr;
    logic [ptr_w:0]           count;
    logic                     full;
    logic                     dup;
    logic                     push;
    logic                     pop;
    state_t                   state;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == (ptr_w + 1)'(depth));
    assign dup  = last_enq_valid && (pred_addr == last_enq);
    assign push = pred_valid && !full && !dup;
    // launch only after ack from the last transfer has dropped
    assign pop  = (state == ST_IDLE) && (count != '0) && !pf_ack;

    assign pf_req = (state == ST_REQ);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            last_enq_valid <= 1'b0;
            state          <= ST_IDLE;
        end else begin
            if (push) begin
                wr_ptr         <= next_ptr(wr_ptr);
                last_enq_valid <= 1'b1;
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            case (state)
                ST_IDLE:     if (pop) state <= ST_REQ;
                ST_REQ:      if (pf_ack) state <= ST_WAIT_LOW;
                ST_WAIT_LOW: if (!pf_ack) state <= ST_IDLE;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= pred_addr;
            last_enq      <= pred_addr;
        end
        if (pop) begin
            pf_addr <= queue[rd_ptr];
        end
    end

    a_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        (pf_req && !pf_ack) |=> (pf_req && $stable(pf_addr))
    ) else $error("prefetch_issue: request dropped or address changed before ack");

    a_req_after_ack_low: assert property (
        @(posedge clk) disable iff (rst)
        $rose(pf_req) |-> !$past(pf_ack)
    ) else $error("prefetch_issue: request raised while ack still high");

endmodule

`default_nettype wire

//--- source/instr_prefetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module instr_prefetch_top (
    input  wire logic                clk,
    input  wire logic                rst,

    input  wire logic                fetch_valid,
    input  prefetch_pkg::line_addr_t fetch_pc,
    output prefetch_pkg::ctr2_t      fetch_conf,
    output logic                     fetch_conf_valid,

    input  wire logic                conf_upd_valid,
    input  prefetch_pkg::line_addr_t conf_upd_pc,
    input  wire logic                conf_upd_up,
    input  prefetch_pkg::ctr2_t      conf_upd_ctr,

    input  wire logic                miss_valid,
    input  prefetch_pkg::line_addr_t miss_addr,
    input  wire logic                miss_is_data,

    output logic                     pf_req,
    output prefetch_pkg::line_addr_t pf_addr,
    input  wire logic                pf_ack
);

    logic                     pred_valid;
    prefetch_pkg::line_addr_t pred_addr;

    target_predictor u_predictor (
        .clk              (clk),
        .rst              (rst),
        .fetch_valid      (fetch_valid),
        .fetch_pc         (fetch_pc),
        .fetch_conf       (fetch_conf),
        .fetch_conf_valid (fetch_conf_valid),
        .conf_upd_valid   (conf_upd_valid),
        .conf_upd_pc      (conf_upd_pc),
        .conf_upd_up      (conf_upd_up),
        .conf_upd_ctr     (conf_upd_ctr),
        .miss_valid       (miss_valid),
        .miss_addr        (miss_addr),
        .miss_is_data     (miss_is_data),
        .pred_valid       (pred_valid),
        .pred_addr        (pred_addr)
    );

    prefetch_issue u_issue (
        .clk        (clk),
        .rst        (rst),
        .pred_valid (pred_valid),
        .pred_addr  (pred_addr),
        .pf_req     (pf_req),
        .pf_addr    (pf_addr),
        .pf_ack     (pf_ack)
    );

endmodule

`default_nettype wire

//--- test/tb_instr_prefetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_cfg.svh"

module tb_instr_prefetch;

    localparam int depth     = `PF_QUEUE_DEPTH;
    localparam int n_entries = 2 ** `PF_HASH_WIDTH;

    logic                        clk;
    logic                        rst;
    logic                        fetch_valid;
    prefetch_pkg::line_addr_t    fetch_pc;
    prefetch_pkg::ctr2_t         fetch_conf;
    logic                        fetch_conf_valid;
    logic                        conf_upd_valid;
    prefetch_pkg::line_addr_t    conf_upd_pc;
    logic                        conf_upd_up;
    prefetch_pkg::ctr2_t         conf_upd_ctr;
    logic                        miss_valid;
    prefetch_pkg::line_addr_t    miss_addr;
    logic                        miss_is_data;
    logic                        pf_req;
    prefetch_pkg::line_addr_t    pf_addr;
    logic                        pf_ack;
    logic                        hold_off;

    // reference model state
    prefetch_pkg::target_entry_t m_tgt [n_entries];
    prefetch_pkg::ctr2_t         m_conf [n_entries];
    prefetch_pkg::target_entry_t m_ent;
    prefetch_pkg::ctr2_t         m_conf_rd;
    prefetch_pkg::tbl_idx_t      m_anneal_idx;
    prefetch_pkg::line_addr_t    m_last_pc;
    prefetch_pkg::line_addr_t    m_last_enq;
    prefetch_pkg::line_addr_t    exp_q [$];
    bit                          m_last_valid;
    bit                          m_lookup;
    bit                          m_stolen;
    bit                          m_last_enq_valid;
    bit                          m_seen_rst;
    int                          m_count;
    int                          m_state;
    int                          resp_cnt;
    int                          errors;
    int                          checks;
    int                          tests_run;
    int                          tests_failed;
    int                          test_err_start;

    instr_prefetch_top dut0 (
        .clk              (clk),
        .rst              (rst),
        .fetch_valid      (fetch_valid),
        .fetch_pc         (fetch_pc),
        .fetch_conf       (fetch_conf),
        .fetch_conf_valid (fetch_conf_valid),
        .conf_upd_valid   (conf_upd_valid),
        .conf_upd_pc      (conf_upd_pc),
        .conf_upd_up      (conf_upd_up),
        .conf_upd_ctr     (conf_upd_ctr),
        .miss_valid       (miss_valid),
        .miss_addr        (miss_addr),
        .miss_is_data     (miss_is_data),
        .pf_req           (pf_req),
        .pf_addr          (pf_addr),
        .pf_ack           (pf_ack)
    );

    always #5 clk = ~clk;

    function automatic prefetch_pkg::ctr2_t sat_step(input prefetch_pkg::ctr2_t c, input bit up);
        if (up) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    function automatic bit in_window(input prefetch_pkg::line_addr_t a);
        return (a >= `PF_WIN0_BASE && a <= `PF_WIN0_LIMIT) ||
               (a >= `PF_WIN1_BASE && a <= `PF_WIN1_LIMIT);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // L2 responder, ack after a random 0..5 cycles
    initial begin
        void'($urandom(32'hbf56));
        forever begin
            @(posedge clk);
            if (rst) begin
                resp_cnt = -1;
                pf_ack <= #1 1'b0;
            end else if (pf_ack) begin
                if (!pf_req) begin
                    pf_ack <= #1 1'b0;
                end
            end else if (pf_req && !hold_off) begin
                if (resp_cnt < 0) begin
                    resp_cnt = int'($urandom % 6);
                end
                if (resp_cnt == 0) begin
                    pf_ack <= #1 1'b1;
                    resp_cnt = -1;
                end else begin
                    resp_cnt--;
                end
            end
        end
    end

    // cycle model: outputs of the cycle ending at this edge, then state updates
    always @(posedge clk) begin : model
        prefetch_pkg::target_entry_t ent_next;
        prefetch_pkg::ctr2_t         conf_next;
        prefetch_pkg::tbl_idx_t      anneal_next;
        prefetch_pkg::line_addr_t    pred;
        prefetch_pkg::line_addr_t    seq_pc;
        bit                          anneal;
        bit                          conf_valid;
        bit                          pred_v;
        bit                          tag_hit;
        bit                          take;
        bit                          push;
        bit                          pop;
        anneal      = miss_valid && !miss_is_data;
        ent_next    = m_tgt[prefetch_pkg::hash_index(fetch_valid ? fetch_pc : m_last_pc)];
        conf_next   = m_conf[prefetch_pkg::hash_index(anneal ? miss_addr : fetch_pc)];
        anneal_next = prefetch_pkg::hash_index(miss_addr);
        if (rst) begin
            if (m_seen_rst) begin
                check_value("pf_req", pf_req, 0);
            end
            m_seen_rst      = 1;
            m_last_valid    = 0;
            m_lookup        = 0;
            m_stolen        = 0;
            m_count         = 0;
            m_state         = 0;
            m_last_enq_valid = 0;
            exp_q.delete();
        end else begin
            conf_valid = m_lookup && !m_stolen;
            check_value("fetch_conf_valid", fetch_conf_valid, conf_valid);
            if (conf_valid) begin
                check_value("fetch_conf", fetch_conf, m_conf_rd);
            end
            check_value("pf_req", pf_req, m_state == 1);
            seq_pc  = m_last_pc + 1;
            tag_hit = m_ent.valid && (m_ent.tag == m_last_pc);
            take    = tag_hit && m_ent.taken[1] && in_window(m_ent.target);
            pred    = take ? m_ent.target : seq_pc;
            pred_v  = conf_valid && m_conf_rd[1];
            if (m_state == 1 && pf_ack) begin
                if (exp_q.size() == 0) begin
                    $display("L2 request for %h completed with none expected", pf_addr);
                    errors++;
                end else begin
                    check_value("pf_addr", pf_addr, exp_q.pop_front());
                end
            end
            push = pred_v && (m_count < depth) && !(m_last_enq_valid && pred == m_last_enq);
            pop  = (m_state == 0) && (m_count != 0) && !pf_ack;
            if (push) begin
                exp_q.push_back(pred);
                m_last_enq       = pred;
                m_last_enq_valid = 1;
            end
            m_count = m_count + int'(push) - int'(pop);
            case (m_state)
                0: if (pop) m_state = 1;
                1: if (pf_ack) m_state = 2;
                default: if (!pf_ack) m_state = 0;
            endcase
            // training of the previous line
            if (fetch_valid && m_last_valid) begin
                m_tgt[prefetch_pkg::hash_index(m_last_pc)] = '{
                    target: fetch_pc,
                    valid:  1'b1,
                    taken:  sat_step(tag_hit ? m_ent.taken : 2'b00, fetch_pc != seq_pc),
                    tag:    m_last_pc
                };
            end
            if (m_stolen) begin
                m_conf[m_anneal_idx] = sat_step(m_conf_rd, 1);
            end else if (conf_upd_valid) begin
                m_conf[prefetch_pkg::hash_index(conf_upd_pc)] =
                    sat_step(conf_upd_ctr, conf_upd_up);
            end
            m_lookup = fetch_valid;
            m_stolen = anneal;
            if (fetch_valid) begin
                m_last_valid = 1;
            end
        end
        if (fetch_valid) begin
            m_last_pc = fetch_pc;
        end
        m_ent        = ent_next;
        m_conf_rd    = conf_next;
        m_anneal_idx = anneal_next;
    end

    // callers sit 1 ns after a rising edge
    task automatic do_fetch(input prefetch_pkg::line_addr_t pc);
        fetch_valid = 1'b1;
        fetch_pc    = pc;
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
    endtask

    task automatic send_update(input prefetch_pkg::line_addr_t pc, input bit up,
                               input prefetch_pkg::ctr2_t ctr);
        conf_upd_valid = 1'b1;
        conf_upd_pc    = pc;
        conf_upd_up    = up;
        conf_upd_ctr   = ctr;
        @(posedge clk);
        #1;
        conf_upd_valid = 1'b0;
    endtask

    task automatic send_miss(input prefetch_pkg::line_addr_t addr, input bit is_data);
        miss_valid   = 1'b1;
        miss_addr    = addr;
        miss_is_data = is_data;
        @(posedge clk);
        #1;
        miss_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        bit done;
        done = 0;
        idle_cycles(3);
        for (int i = 0; i < 400; i++) begin
            if (exp_q.size() == 0 && m_count == 0 && m_state == 0 && !pf_req && !pf_ack) begin
                done = 1;
                break;
            end
            idle_cycles(1);
        end
        if (!done) begin
            $display("timeout: prefetch queue did not drain, %0d requests left", exp_q.size());
            $display("TEST FAILED");
            $finish;
        end
    endtask

    task automatic end_test(input int n, input string name);
        tests_run++;
        if (errors != test_err_start) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", n, name, (errors != test_err_start) ? "failed" : "passed");
        test_err_start = errors;
    endtask

    initial begin
        for (int i = 0; i < n_entries; i++) begin
            m_tgt[i]  = '0;
            m_conf[i] = 2'b10;
        end
        clk            = 1'b0;
        rst            = 1'b1;
        fetch_valid    = 1'b0;
        fetch_pc       = '0;
        conf_upd_valid = 1'b0;
        conf_upd_pc    = '0;
        conf_upd_up    = 1'b0;
        conf_upd_ctr   = '0;
        miss_valid     = 1'b0;
        miss_addr      = '0;
        miss_is_data   = 1'b0;
        pf_ack         = 1'b0;
        hold_off       = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        end_test(0, "reset");

        for (int i = 0; i < 6; i++) begin
            do_fetch(27'h0000100 + i);
            idle_cycles(10);
        end
        wait_drain();
        end_test(1, "sequential prediction");

        // A in window 0, B in window 1
        for (int i = 0; i < 3; i++) begin
            do_fetch(27'h0001000);
            idle_cycles(10);
            do_fetch(27'h2000400);
            idle_cycles(10);
        end
        do_fetch(27'h0001000);
        wait_drain();
        end_test(2, "branch training");

        // target between the windows
        for (int i = 0; i < 3; i++) begin
            do_fetch(27'h0002000);
            idle_cycles(10);
            do_fetch(27'h1000000);
            idle_cycles(10);
        end
        do_fetch(27'h0002000);
        wait_drain();
        end_test(3, "window holes");

        send_update(27'h0001000, 1'b0, 2'b10);
        do_fetch(27'h0001000);
        idle_cycles(10);
        send_miss(27'h0001000, 1'b1);
        do_fetch(27'h0001000);
        idle_cycles(10);
        send_miss(27'h0001000, 1'b0);
        idle_cycles(2);
        send_miss(27'h0001000, 1'b0);
        idle_cycles(2);
        do_fetch(27'h0001000);
        wait_drain();
        end_test(4, "confidence control");

        // miss and fetch in one cycle, update right after
        fetch_valid  = 1'b1;
        fetch_pc     = 27'h0003000;
        miss_valid   = 1'b1;
        miss_addr    = 27'h0003000;
        miss_is_data = 1'b0;
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
        miss_valid  = 1'b0;
        send_update(27'h0003000, 1'b0, 2'b11);
        idle_cycles(2);
        do_fetch(27'h0003000);
        wait_drain();
        end_test(5, "annealing priority");

        hold_off = 1'b1;
        do_fetch(27'h0004000);
        do_fetch(27'h0004000);
        for (int i = 0; i < 8; i++) begin
            do_fetch(27'h0005000 + 2 * i);
        end
        idle_cycles(20);
        hold_off = 1'b0;
        wait_drain();
        end_test(6, "back-pressure");

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- prefetch.f
+incdir+include
source/prefetch_pkg.sv
source/table_ram.sv
source/io_window_check.sv
source/target_predictor.sv
source/prefetch_issue.sv
source/instr_prefetch_top.sv
test/tb_instr_prefetch.sv

//--- Bender.yml
package:
  name: prefetch

export_include_dirs:
  - include

sources:
  - files:
      - source/prefetch_pkg.sv
      - source/table_ram.sv
      - source/io_window_check.sv
      - source/target_predictor.sv
      - source/prefetch_issue.sv
      - source/instr_prefetch_top.sv
  - target: test
    files:
      - test/tb_instr_prefetch.sv
